// File: Makefile
# Verilator build and run of the edge node testbench

VERILATOR ?= verilator
TOP       ?= ndn_node_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= Something failed
PASS_MSG  ?= Everything OK

BIN := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard rtl/*.sv rtl/*.svh sim/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Result comes from the log, the simulator status is not trusted alone
run: compile
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: list.f
+incdir+rtl
rtl/ndn_pkg.sv
rtl/mcu_serial_rx.sv
rtl/content_store.sv
rtl/mcu_serial_tx.sv
rtl/ndn_mcu_node.sv
sim/ndn_node_tb.sv

// File: rtl/content_store.sv
// Content store, longest-prefix match of interests against loadable entries
`timescale 1ns/1ps
`include "ndn_consts.svh"

module content_store (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 fill_valid,
    output logic                 fill_ready,
    input  ndn_pkg::cs_fill_t    fill_entry,
    input  logic                 interest_valid,
    output logic                 interest_ready,
    input  ndn_pkg::interest_t   interest,
    output logic                 pkt_valid,
    input  logic                 pkt_ready,
    output ndn_pkg::data_pkt_t   pkt,
    output ndn_pkg::miss_count_t miss_count
);
    import ndn_pkg::*;

    // Entry storage
    logic        ent_valid   [`NDN_CS_ENTRIES];
    prefix_len_t ent_len     [`NDN_CS_ENTRIES];
    prefix_t     ent_prefix  [`NDN_CS_ENTRIES];
    payload_t    ent_payload [`NDN_CS_ENTRIES];

    // Lookup result
    logic        found;
    slot_t       best_slot;
    prefix_len_t best_len;
    logic        accept;

    // Mask with the top len bits set
    function automatic prefix_t top_mask(input prefix_len_t len);
        top_mask = ~({`NDN_PREFIX_W{1'b1}} >> len);
    endfunction

    // Host writes are never stalled
    assign fill_ready = 1'b1;

    // Busy only while a hit waits for the transmitter
    assign interest_ready = !pkt_valid;
    assign accept         = interest_valid && interest_ready;

    // Parallel compare, strict greater keeps the lowest slot on a tie
    always_comb begin
        found     = 1'b0;
        best_slot = '0;
        best_len  = '0;
        for (int i = 0; i < `NDN_CS_ENTRIES; i++) begin
            if (ent_valid[i] && (ent_len[i] <= interest.len) &&
                (((ent_prefix[i] ^ interest.prefix) & top_mask(ent_len[i])) == '0)) begin
                if (!found || (ent_len[i] > best_len)) begin
                    found     = 1'b1;
                    best_slot = slot_t'(i);
                    best_len  = ent_len[i];
                end
            end
        end
    end

    // Valid bits and result control
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `NDN_CS_ENTRIES; i++) begin
                ent_valid[i] <= 1'b0;
            end
            pkt_valid  <= 1'b0;
            miss_count <= '0;
        end else begin
            if (fill_valid) begin
                ent_valid[fill_entry.slot] <= 1'b1;
            end
            if (accept && found) begin
                pkt_valid <= 1'b1;
            end else if (pkt_valid && pkt_ready) begin
                pkt_valid <= 1'b0;
            end
            // A miss is final
            if (accept && !found) begin
                miss_count <= miss_count + 1'b1;
            end
        end
    end

    // Entry contents and outgoing packet, lookup reads the old entry on a same-cycle fill
    always_ff @(posedge clk) begin
        if (fill_valid) begin
            ent_len[fill_entry.slot]     <= fill_entry.len;
            ent_prefix[fill_entry.slot]  <= fill_entry.prefix;
            ent_payload[fill_entry.slot] <= fill_entry.payload;
        end
        if (accept && found) begin
            pkt.prefix  <= ent_prefix[best_slot];
            pkt.payload <= ent_payload[best_slot];
        end
    end

    // Packet stays offered until the transmitter takes it
    a_pkt_held: assert property (
        @(posedge clk) disable iff (rst)
        pkt_valid && !pkt_ready |=> pkt_valid && $stable(pkt)
    );

endmodule

// File: rtl/mcu_serial_rx.sv
// Interest receiver, turns start bit, length and prefix on mosi into a valid/ready interest
`timescale 1ns/1ps
`include "ndn_consts.svh"

module mcu_serial_rx (
    input  logic               clk,
    input  logic               rst,
    input  logic               mosi,
    output logic               interest_valid,
    input  logic               interest_ready,
    output ndn_pkg::interest_t interest
);
    import ndn_pkg::*;

    // Index wide enough for the longest field
    localparam int IDX_W = $clog2(`NDN_PREFIX_W);

    rx_state_t        state;
    logic [IDX_W-1:0] bit_idx;

    // Held interest is offered until the store takes it
    assign interest_valid = (state == RX_HOLD);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= RX_IDLE;
            bit_idx <= '0;
        end else begin
            case (state)
                RX_IDLE: begin
                    // Low line is the start bit
                    if (!mosi) begin
                        state   <= RX_LEN;
                        bit_idx <= IDX_W'(`NDN_LEN_W - 1);
                    end
                end
                RX_LEN: begin
                    if (bit_idx == '0) begin
                        state   <= RX_PREFIX;
                        bit_idx <= IDX_W'(`NDN_PREFIX_W - 1);
                    end else begin
                        bit_idx <= bit_idx - 1'b1;
                    end
                end
                RX_PREFIX: begin
                    // Last prefix bit, interest valid from the next cycle
                    if (bit_idx == '0) begin
                        state <= RX_HOLD;
                    end else begin
                        bit_idx <= bit_idx - 1'b1;
                    end
                end
                RX_HOLD: begin
                    // mosi ignored here until the store accepts
                    if (interest_ready) begin
                        state <= RX_IDLE;
                    end
                end
                default: begin
                    state <= RX_IDLE;
                end
            endcase
        end
    end

    // Fields shift in MSB first
    always_ff @(posedge clk) begin
        if (state == RX_LEN) begin
            interest.len <= {interest.len[`NDN_LEN_W-2:0], mosi};
        end
        if (state == RX_PREFIX) begin
            interest.prefix <= {interest.prefix[`NDN_PREFIX_W-2:0], mosi};
        end
    end

    // Offered interest must not change under back-pressure
    a_interest_stable: assert property (
        @(posedge clk) disable iff (rst)
        interest_valid && !interest_ready |=> interest_valid && $stable(interest)
    );

endmodule

// File: rtl/mcu_serial_tx.sv
// Data transmitter, sends start bit, prefix and payload of a data packet on miso
`timescale 1ns/1ps
`include "ndn_consts.svh"

module mcu_serial_tx (
    input  logic               clk,
    input  logic               rst,
    input  logic               pkt_valid,
    output logic               pkt_ready,
    input  ndn_pkg::data_pkt_t pkt,
    output logic               miso
);
    import ndn_pkg::*;

    // Bits after the start bit and the counter that spans them
    localparam int FRAME_BITS = `NDN_PREFIX_W + `NDN_PAYLOAD_W;
    localparam int CNT_W      = $clog2(FRAME_BITS + 1);

    tx_state_t             state;
    logic [CNT_W-1:0]      bit_cnt;
    logic [FRAME_BITS-1:0] shreg;

    // Takes a packet only between frames
    assign pkt_ready = (state == TX_IDLE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= TX_IDLE;
            bit_cnt <= '0;
            miso    <= 1'b1;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (pkt_valid) begin
                        // Start bit
                        miso    <= 1'b0;
                        bit_cnt <= '0;
                        state   <= TX_START;
                    end
                end
                TX_START: begin
                    miso    <= shreg[FRAME_BITS-1];
                    bit_cnt <= bit_cnt + 1'b1;
                    state   <= TX_PREFIX;
                end
                TX_PREFIX: begin
                    miso    <= shreg[FRAME_BITS-1];
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == CNT_W'(`NDN_PREFIX_W - 1)) begin
                        state <= TX_PAYLOAD;
                    end
                end
                TX_PAYLOAD: begin
                    // All bits out, line back to idle high
                    if (bit_cnt == CNT_W'(FRAME_BITS)) begin
                        miso  <= 1'b1;
                        state <= TX_IDLE;
                    end else begin
                        miso    <= shreg[FRAME_BITS-1];
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                default: begin
                    miso  <= 1'b1;
                    state <= TX_IDLE;
                end
            endcase
        end
    end

    // Prefix in the upper bits, so MSB first covers prefix then payload
    always_ff @(posedge clk) begin
        if (state == TX_IDLE && pkt_valid) begin
            shreg <= pkt;
        end else if (state != TX_IDLE) begin
            shreg <= {shreg[FRAME_BITS-2:0], 1'b0};
        end
    end

    // Line idles high
    a_idle_high: assert property (
        @(posedge clk) disable iff (rst)
        state == TX_IDLE |-> miso
    );

endmodule

// File: rtl/ndn_consts.svh
// Widths and depths of the edge node, included by the package, the RTL and the testbench
`ifndef NDN_CONSTS_SVH
`define NDN_CONSTS_SVH

// Name prefix is one 64-bit word
`define NDN_PREFIX_W 64

// Prefix length field, top L bits of the prefix are significant
`define NDN_LEN_W 6

// Data payload, 32 bytes
`define NDN_PAYLOAD_W 256

// Content store depth and matching slot index width
`define NDN_CS_ENTRIES 4
`define NDN_SLOT_W 2

// Miss counter width, wraps on overflow
`define NDN_MISS_W 16

`endif

// File: rtl/ndn_mcu_node.sv
// Edge node top, serial receiver into content store into serial transmitter
`timescale 1ns/1ps

module ndn_mcu_node (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 mosi,
    output logic                 miso,
    input  logic                 fill_valid,
    output logic                 fill_ready,
    input  ndn_pkg::cs_fill_t    fill_entry,
    output ndn_pkg::miss_count_t miss_count
);
    import ndn_pkg::*;

    // Receiver to store
    logic      interest_valid;
    logic      interest_ready;
    interest_t interest;

    // Store to transmitter
    logic      pkt_valid;
    logic      pkt_ready;
    data_pkt_t pkt;

    mcu_serial_rx u_rx (
        .clk            (clk),
        .rst            (rst),
        .mosi           (mosi),
        .interest_valid (interest_valid),
        .interest_ready (interest_ready),
        .interest       (interest)
    );

    content_store u_cs (
        .clk            (clk),
        .rst            (rst),
        .fill_valid     (fill_valid),
        .fill_ready     (fill_ready),
        .fill_entry     (fill_entry),
        .interest_valid (interest_valid),
        .interest_ready (interest_ready),
        .interest       (interest),
        .pkt_valid      (pkt_valid),
        .pkt_ready      (pkt_ready),
        .pkt            (pkt),
        .miss_count     (miss_count)
    );

    mcu_serial_tx u_tx (
        .clk       (clk),
        .rst       (rst),
        .pkt_valid (pkt_valid),
        .pkt_ready (pkt_ready),
        .pkt       (pkt),
        .miso      (miso)
    );

endmodule

// File: rtl/ndn_pkg.sv
// Shared types of the edge node, imported by every RTL module and the testbench
`include "ndn_consts.svh"

package ndn_pkg;

    // Plain vectors with a meaning
    typedef logic [`NDN_PREFIX_W-1:0]  prefix_t;
    typedef logic [`NDN_LEN_W-1:0]     prefix_len_t;
    typedef logic [`NDN_PAYLOAD_W-1:0] payload_t;
    typedef logic [`NDN_SLOT_W-1:0]    slot_t;
    typedef logic [`NDN_MISS_W-1:0]    miss_count_t;

    // Interest as decoded from mosi
    typedef struct packed {
        prefix_len_t len;
        prefix_t     prefix;
    } interest_t;

    // Data packet, prefix goes out first on miso
    typedef struct packed {
        prefix_t  prefix;
        payload_t payload;
    } data_pkt_t;

    // One store entry write from the host port
    typedef struct packed {
        slot_t       slot;
        prefix_len_t len;
        prefix_t     prefix;
        payload_t    payload;
    } cs_fill_t;

    // Serial state machines
    typedef enum logic [1:0] {RX_IDLE, RX_LEN, RX_PREFIX, RX_HOLD} rx_state_t;
    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_PREFIX, TX_PAYLOAD} tx_state_t;

endpackage

// File: sim/ndn_node_tb.sv
// Self-checking testbench for the edge node that sends interests on mosi and decodes data frames on miso
`timescale 1ns/1ps
`include "ndn_consts.svh"

module ndn_node_tb;
    import ndn_pkg::*;

    // Interests over all tests set the cycle limit
    localparam int NUM_INTERESTS = 50;
    localparam int MAX_CYCLES    = 400 * NUM_INTERESTS + 2000;
    localparam int FRAME_BITS    = `NDN_PREFIX_W + `NDN_PAYLOAD_W;

    logic        clk;
    logic        rst;
    logic        mosi;
    logic        miso;
    logic        fill_valid;
    logic        fill_ready;
    cs_fill_t    fill_entry;
    miss_count_t miss_count;

    // Reference copy of the store
    logic        ref_valid   [`NDN_CS_ENTRIES];
    prefix_len_t ref_len     [`NDN_CS_ENTRIES];
    prefix_t     ref_prefix  [`NDN_CS_ENTRIES];
    payload_t    ref_payload [`NDN_CS_ENTRIES];

    data_pkt_t   expected_q[$];
    miss_count_t expected_misses;
    int          cycles = 0;

    ndn_mcu_node dut (
        .clk        (clk),
        .rst        (rst),
        .mosi       (mosi),
        .miso       (miso),
        .fill_valid (fill_valid),
        .fill_ready (fill_ready),
        .fill_entry (fill_entry),
        .miss_count (miss_count)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "Run stopped");
    endtask

    task automatic check_pkt(input data_pkt_t got, input data_pkt_t exp);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH at %0t: data packet prefix %h payload %h, expected %h %h",
                                $time, got.prefix, got.payload, exp.prefix, exp.payload));
        end
    endtask

    task automatic check_miss(input miss_count_t got, input miss_count_t exp);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH at %0t: miss count %0d, expected %0d", $time, got, exp));
        end
    endtask

    // Longest match compared bit by bit over the top E bits where the lowest slot wins a tie
    function automatic logic lookup_ref(input interest_t req, output data_pkt_t hit_pkt);
        logic found;
        logic same;
        int   best_len;
        found    = 1'b0;
        best_len = -1;
        hit_pkt  = '0;
        for (int i = 0; i < `NDN_CS_ENTRIES; i++) begin
            same = 1'b1;
            for (int b = 0; b < int'(ref_len[i]); b++) begin
                if (ref_prefix[i][`NDN_PREFIX_W-1-b] != req.prefix[`NDN_PREFIX_W-1-b]) begin
                    same = 1'b0;
                end
            end
            if (ref_valid[i] && ref_len[i] <= req.len && same && int'(ref_len[i]) > best_len) begin
                found    = 1'b1;
                best_len = int'(ref_len[i]);
                hit_pkt  = {ref_prefix[i], ref_payload[i]};
            end
        end
        return found;
    endfunction

    function automatic prefix_t rand_prefix();
        return {$urandom, $urandom};
    endfunction

    function automatic payload_t rand_payload();
        payload_t p;
        for (int w = 0; w < `NDN_PAYLOAD_W / 32; w++) begin
            p[w*32 +: 32] = $urandom;
        end
        return p;
    endfunction

    // One write through the fill port with the reference updated once it is taken
    task automatic load_entry(input slot_t slot, input prefix_len_t len, input prefix_t prefix,
                              input payload_t payload);
        @(posedge clk);
        fill_valid <= 1'b1;
        fill_entry <= '{slot: slot, len: len, prefix: prefix, payload: payload};
        @(negedge clk);
        while (!fill_ready) @(negedge clk);
        @(posedge clk);
        fill_valid        <= 1'b0;
        ref_valid[slot]   = 1'b1;
        ref_len[slot]     = len;
        ref_prefix[slot]  = prefix;
        ref_payload[slot] = payload;
    endtask

    // Start bit, length and prefix followed by 3 idle cycles
    task automatic send_interest(input prefix_len_t len, input prefix_t prefix);
        data_pkt_t                           exp;
        logic [`NDN_LEN_W+`NDN_PREFIX_W-1:0] bits;
        bits = {len, prefix};
        // Receiver ignores mosi while it still holds an interest
        @(negedge clk);
        while (dut.u_rx.interest_valid) @(negedge clk);
        if (lookup_ref('{len: len, prefix: prefix}, exp)) begin
            expected_q.push_back(exp);
        end else begin
            expected_misses = expected_misses + 1'b1;
        end
        @(posedge clk);
        mosi <= 1'b0;
        for (int i = `NDN_LEN_W + `NDN_PREFIX_W - 1; i >= 0; i--) begin
            @(posedge clk);
            mosi <= bits[i];
        end
        @(posedge clk);
        mosi <= 1'b1;
        repeat (3) @(posedge clk);
    endtask

    // All packets out and the receiver empty
    task automatic wait_drain();
        @(negedge clk);
        while (expected_q.size() != 0 || dut.u_rx.interest_valid) @(negedge clk);
    endtask

    // miso decoder expects a start bit then 320 bits MSB first
    initial begin : miso_decoder
        logic [FRAME_BITS-1:0] frame;
        @(negedge rst);
        forever begin
            @(negedge clk);
            if (miso === 1'b0) begin
                for (int i = FRAME_BITS - 1; i >= 0; i--) begin
                    @(negedge clk);
                    frame[i] = miso;
                end
                if (expected_q.size() == 0) begin
                    abort_run("A frame arrived on miso while no data packet was expected");
                end else begin
                    check_pkt(data_pkt_t'(frame), expected_q.pop_front());
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            abort_run("Timeout, the tests did not finish within the cycle limit");
        end
    end

    initial begin : main
        prefix_t base;
        prefix_t p1;
        rst             = 1'b1;
        mosi            = 1'b1;
        fill_valid      = 1'b0;
        fill_entry      = '0;
        expected_misses = '0;
        for (int i = 0; i < `NDN_CS_ENTRIES; i++) begin
            ref_valid[i] = 1'b0;
        end
        void'($urandom(32'h2c2c81d8));
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_miss(miss_count, expected_misses);

        // Exact hit on a full-length entry
        p1 = rand_prefix();
        load_entry(2'd0, 6'd63, p1, rand_payload());
        send_interest(6'd63, p1);
        wait_drain();

        // Nested entries 8, 16, 32 with shared top bits
        base = rand_prefix();
        load_entry(2'd1, 6'd8, base, rand_payload());
        load_entry(2'd2, 6'd16, base, rand_payload());
        load_entry(2'd3, 6'd32, base, rand_payload());
        send_interest(6'd63, base);
        send_interest(6'd63, base ^ (64'h1 << 43));
        send_interest(6'd63, base ^ (64'h1 << 53));
        send_interest(6'd12, base);
        send_interest(6'd20, base);
        wait_drain();

        // Misses where the top bit differs or the interest is shorter than every entry
        send_interest(6'd63, base ^ (64'h1 << 63));
        @(negedge clk);
        check_miss(miss_count, expected_misses);
        send_interest(6'd4, base);
        @(negedge clk);
        check_miss(miss_count, expected_misses);
        wait_drain();

        // Refill changes later results
        load_entry(2'd1, 6'd8, base, rand_payload());
        send_interest(6'd12, base);
        load_entry(2'd3, 6'd32, ~base, rand_payload());
        send_interest(6'd63, base);
        wait_drain();

        // Random back-to-back traffic lets the transmitter throttle the store
        // Random byte sits inside the significant bits of the longer entries
        for (int s = 0; s < `NDN_CS_ENTRIES; s++) begin
            load_entry(slot_t'(s), prefix_len_t'($urandom_range(8, 40)),
                       {base[63:40], 8'($urandom_range(0, 255)), 32'h0}, rand_payload());
        end
        for (int n = 0; n < 40; n++) begin
            send_interest(prefix_len_t'($urandom_range(0, 63)),
                          ref_prefix[$urandom_range(0, 3)] ^ (64'h1 << $urandom_range(0, 63)));
        end
        wait_drain();
        check_miss(miss_count, expected_misses);

        $display("Everything OK");
        $finish;
    end

endmodule
